// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - source/dcache_pkg.sv
      - source/dcache_fsm.sv
      - source/flush_counter.sv
      - source/cache_ways.sv
      - source/line_merge.sv
      - source/mem_port.sv
      - source/dcache_top.sv
  - target: test
    files:
      - test/dcache_props.sv
      - test/tb_dcache.sv

// ==== source/cache_ways.sv ====
`timescale 1ns/10ps

module cache_ways
(
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  dcache_pkg::dc_addr_u                lookup_addr_i,
    input  logic                                busy_flushing_i,
    input  logic [dcache_pkg::INDEX_BITS-1:0]   walk_set_i,
    input  logic [dcache_pkg::WAY_BITS-1:0]     walk_way_i,
    input  logic                                st_analysis_i,
    input  logic                                st_fill_i,
    input  logic                                st_fill_done_i,
    input  logic                                m_ready_i,
    input  logic                                req_rw_i,
    input  logic [dcache_pkg::LINE_W-1:0]       write_line_i,
    output logic                                hit_o,
    output logic [dcache_pkg::LINE_W-1:0]       hit_line_o,
    output logic [dcache_pkg::LINE_W-1:0]       victim_line_o,
    output logic [dcache_pkg::TAG_BITS-1:0]     victim_tag_o,
    output logic                                victim_dirty_o,
    output logic                                walk_dirty_o,
    output logic [dcache_pkg::LINE_W-1:0]       walk_line_o,
    output logic [dcache_pkg::TAG_BITS-1:0]     walk_tag_o
);
    import dcache_pkg::*;

    logic [TAG_BITS-1:0]   tag_rd  [N_WAYS];
    logic [LINE_W-1:0]     data_rd [N_WAYS];
    logic [N_WAYS-1:0]     valid   [N_SETS];
    logic [N_WAYS-1:0]     dirty   [N_SETS];
    logic [WAY_BITS-1:0]   fifo_ptr [N_SETS];   // Next victim per set
    logic [N_WAYS-1:0]     way_hit;
    logic [WAY_BITS-1:0]   hit_way;
    logic [WAY_BITS-1:0]   victim_way;
    logic [INDEX_BITS-1:0] idx;
    logic [INDEX_BITS-1:0] rd_set;
    logic                  write_hit;

    assign idx        = lookup_addr_i.f.index;
    assign rd_set     = busy_flushing_i ? walk_set_i : idx;   // Walk owns the read port
    assign victim_way = fifo_ptr[idx];
    assign write_hit  = st_analysis_i && !busy_flushing_i && hit_o && req_rw_i;

    // ==========================================================
    // Tag and data arrays, one pair per way
    // ==========================================================
    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        logic [TAG_BITS-1:0] tag_mem  [N_SETS];
        logic [LINE_W-1:0]   data_mem [N_SETS];
        logic                way_we;

        assign way_hit[w] = valid[idx][w] && (tag_rd[w] == lookup_addr_i.f.tag);
        assign way_we     = (write_hit && way_hit[w])
                          || (st_fill_done_i && victim_way == WAY_BITS'(w));

        always_ff @(posedge clk_i)
        begin
            if (way_we)
            begin
                tag_mem[idx]  <= lookup_addr_i.f.tag;
                data_mem[idx] <= write_line_i;
            end
            tag_rd[w]  <= tag_mem[rd_set];    // Read first, valid next cycle
            data_rd[w] <= data_mem[rd_set];
        end
    end

    // One-hot hit to way number
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++)
            if (way_hit[w])
                hit_way = WAY_BITS'(w);
    end

    // Valid, dirty and FIFO state
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
            begin
                valid[s]    <= '0;
                dirty[s]    <= '0;
                fifo_ptr[s] <= '0;
            end
        end
        else if (busy_flushing_i)
        begin
            if (m_ready_i)
                dirty[walk_set_i][walk_way_i] <= 1'b0;   // Walked line now in memory
        end
        else
        begin
            if (st_fill_i && m_ready_i)
            begin
                valid[idx][victim_way] <= 1'b1;
                dirty[idx][victim_way] <= req_rw_i;   // Write miss leaves it dirty
            end
            if (write_hit)
                dirty[idx][hit_way] <= 1'b1;
            if (st_fill_done_i)
                fifo_ptr[idx] <= fifo_ptr[idx] + 1'b1;
        end
    end

    assign hit_o          = |way_hit;
    assign hit_line_o     = data_rd[hit_way];
    assign victim_line_o  = data_rd[victim_way];
    assign victim_tag_o   = tag_rd[victim_way];
    assign victim_dirty_o = dirty[idx][victim_way];
    assign walk_dirty_o   = dirty[walk_set_i][walk_way_i];
    assign walk_line_o    = data_rd[walk_way_i];
    assign walk_tag_o     = tag_rd[walk_way_i];

endmodule

// ==== source/dcache_fsm.sv ====
`timescale 1ns/10ps

module dcache_fsm
(
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            p_strobe_i,
    input  logic                            p_flush_i,
    input  logic                            p_rw_i,
    input  dcache_pkg::dc_addr_u            p_addr_i,
    input  logic [dcache_pkg::XLEN-1:0]     p_data_i,
    input  logic [dcache_pkg::XLEN/8-1:0]   p_byte_enable_i,
    input  logic                            hit_i,
    input  logic                            victim_dirty_i,
    input  logic                            walk_dirty_i,
    input  logic                            walk_end_i,
    input  logic                            m_ready_i,
    output logic                            p_ready_o,
    output logic                            busy_flushing_o,
    output dcache_pkg::dc_addr_u            req_addr_o,
    output logic                            req_rw_o,
    output logic [dcache_pkg::XLEN-1:0]     req_data_o,
    output logic [dcache_pkg::XLEN/8-1:0]   req_be_o,
    output logic                            st_analysis_o,
    output logic                            st_wb_victim_o,
    output logic                            st_fill_o,
    output logic                            st_fill_done_o,
    output logic                            st_wb_walk_o,
    output logic                            walk_step_o
);
    import dcache_pkg::*;

    localparam logic [2:0] S_IDLE      = 3'd0,
                           S_ANALYSIS  = 3'd1,
                           S_WB_VICTIM = 3'd2,
                           S_WB_DONE   = 3'd3,
                           S_FILL      = 3'd4,
                           S_FILL_DONE = 3'd5,
                           S_WB_WALK   = 3'd6,
                           S_WALK_DONE = 3'd7;

    logic [2:0] state, state_nxt;
    dc_addr_u   req_addr_r;

    // ==========================================================
    // State register and next state
    // ==========================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;   // Hold while waiting on memory
        case (state)
            S_IDLE:
                if (p_flush_i || p_strobe_i)
                    state_nxt = S_ANALYSIS;
            S_ANALYSIS:
                if (busy_flushing_o)
                    state_nxt = S_WB_WALK;                           // Start the walk
                else if (!hit_i)
                    state_nxt = victim_dirty_i ? S_WB_VICTIM : S_FILL;
                else
                    state_nxt = S_IDLE;                              // Hit, done
            S_WB_VICTIM:
                if (m_ready_i)
                    state_nxt = S_WB_DONE;
            S_WB_DONE:
                state_nxt = S_FILL;
            S_FILL:
                if (m_ready_i)
                    state_nxt = S_FILL_DONE;
            S_FILL_DONE:
                state_nxt = S_IDLE;
            S_WB_WALK:
                if (walk_step_o)
                    state_nxt = S_WALK_DONE;
            S_WALK_DONE:
                state_nxt = walk_end_i ? S_IDLE : S_WB_WALK;
            default:
                state_nxt = S_IDLE;
        endcase
    end

    // Request registers, loaded every idle cycle
    always_ff @(posedge clk_i)
    begin
        if (state == S_IDLE)
        begin
            req_addr_r <= p_addr_i;
            req_rw_o   <= p_rw_i;
            req_data_o <= p_data_i;
            req_be_o   <= p_byte_enable_i;
        end
    end

    // Live address while idle so the arrays read the incoming set
    assign req_addr_o = (state == S_IDLE) ? p_addr_i : req_addr_r;

    // Flush in progress flag
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            busy_flushing_o <= 1'b0;
        else if (state == S_IDLE)
            busy_flushing_o <= p_flush_i;
        else if (state == S_WALK_DONE && walk_end_i)
            busy_flushing_o <= 1'b0;
    end

    // State decodes for the datapath
    assign st_analysis_o  = (state == S_ANALYSIS);
    assign st_wb_victim_o = (state == S_WB_VICTIM);
    assign st_fill_o      = (state == S_FILL);
    assign st_fill_done_o = (state == S_FILL_DONE);
    assign st_wb_walk_o   = (state == S_WB_WALK);
    assign walk_step_o    = st_wb_walk_o && (!walk_dirty_i || m_ready_i);   // Clean or written

    assign p_ready_o = (st_analysis_o && !busy_flushing_o && hit_i)
                     || st_fill_done_o
                     || (state == S_WALK_DONE && walk_end_i);

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    // ==========================================================
    // Cache geometry, 16 sets x 4 ways x 32 bytes = 2 KiB
    // ==========================================================
    localparam int XLEN           = 32;   // Processor word
    localparam int LINE_W         = 256;  // One line on the memory port
    localparam int N_WAYS         = 4;
    localparam int N_SETS         = 16;
    localparam int WORDS_PER_LINE = LINE_W / XLEN;

    // Address field widths
    localparam int BYTE_BITS   = 2;   // Byte within word
    localparam int OFFSET_BITS = 3;   // Word within line
    localparam int INDEX_BITS  = 4;   // Set select
    localparam int WAY_BITS    = 2;
    localparam int TAG_BITS    = XLEN - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    // Word 0 of a line sits in the top bits of the line
    // Raw word for memory, fields for lookup
    typedef union packed {
        logic [XLEN-1:0] word;
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [INDEX_BITS-1:0]  index;
            logic [OFFSET_BITS-1:0] offset;
            logic [BYTE_BITS-1:0]   byte_sel;
        } f;
    } dc_addr_u;

endpackage

// ==== source/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top
(
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            p_strobe_i,
    input  logic                            p_rw_i,
    input  logic [dcache_pkg::XLEN/8-1:0]   p_byte_enable_i,
    input  dcache_pkg::dc_addr_u            p_addr_i,
    input  logic [dcache_pkg::XLEN-1:0]     p_data_i,
    input  logic                            p_flush_i,
    output logic [dcache_pkg::XLEN-1:0]     p_data_o,
    output logic                            p_ready_o,
    output logic                            busy_flushing_o,
    output dcache_pkg::dc_addr_u            m_addr_o,
    input  logic [dcache_pkg::LINE_W-1:0]   m_data_i,
    output logic [dcache_pkg::LINE_W-1:0]   m_data_o,
    output logic                            m_strobe_o,
    output logic                            m_rw_o,
    input  logic                            m_ready_i
);
    import dcache_pkg::*;

    dc_addr_u              req_addr;
    logic                  req_rw;
    logic [XLEN-1:0]       req_data;
    logic [XLEN/8-1:0]     req_be;
    logic                  st_analysis, st_wb_victim, st_fill, st_fill_done, st_wb_walk;
    logic                  walk_step, walk_end, walk_dirty, victim_dirty, hit;
    logic [INDEX_BITS-1:0] walk_set;
    logic [WAY_BITS-1:0]   walk_way;
    logic [TAG_BITS-1:0]   victim_tag, walk_tag;
    logic [LINE_W-1:0]     hit_line, victim_line, walk_line, fill_line;
    logic [LINE_W-1:0]     base_line, write_line;

    assign base_line = st_fill_done ? fill_line : hit_line;   // Merge source

    dcache_fsm u_fsm (
        .clk_i, .rst_i, .p_strobe_i, .p_flush_i, .p_rw_i, .p_addr_i, .p_data_i,
        .p_byte_enable_i, .hit_i(hit), .victim_dirty_i(victim_dirty),
        .walk_dirty_i(walk_dirty), .walk_end_i(walk_end), .m_ready_i, .p_ready_o,
        .busy_flushing_o, .req_addr_o(req_addr), .req_rw_o(req_rw), .req_data_o(req_data),
        .req_be_o(req_be), .st_analysis_o(st_analysis), .st_wb_victim_o(st_wb_victim),
        .st_fill_o(st_fill), .st_fill_done_o(st_fill_done), .st_wb_walk_o(st_wb_walk),
        .walk_step_o(walk_step)
    );

    flush_counter u_walk (
        .clk_i, .rst_i, .walk_step_i(walk_step), .walk_set_o(walk_set),
        .walk_way_o(walk_way), .walk_end_o(walk_end)
    );

    cache_ways u_ways (
        .clk_i, .rst_i, .lookup_addr_i(req_addr), .busy_flushing_i(busy_flushing_o),
        .walk_set_i(walk_set), .walk_way_i(walk_way), .st_analysis_i(st_analysis),
        .st_fill_i(st_fill), .st_fill_done_i(st_fill_done), .m_ready_i,
        .req_rw_i(req_rw), .write_line_i(write_line), .hit_o(hit), .hit_line_o(hit_line),
        .victim_line_o(victim_line), .victim_tag_o(victim_tag),
        .victim_dirty_o(victim_dirty), .walk_dirty_o(walk_dirty),
        .walk_line_o(walk_line), .walk_tag_o(walk_tag)
    );

    line_merge u_merge (
        .offset_i(req_addr.f.offset), .be_i(req_be), .wdata_i(req_data),
        .req_rw_i(req_rw), .base_line_i(base_line), .rdata_o(p_data_o),
        .write_line_o(write_line)
    );

    mem_port u_mem (
        .clk_i, .rst_i, .m_ready_i, .m_data_i, .st_wb_victim_i(st_wb_victim),
        .st_fill_i(st_fill), .st_wb_walk_i(st_wb_walk), .walk_dirty_i(walk_dirty),
        .req_addr_i(req_addr), .victim_tag_i(victim_tag), .victim_line_i(victim_line),
        .walk_set_i(walk_set), .walk_tag_i(walk_tag), .walk_line_i(walk_line),
        .m_addr_o, .m_data_o, .m_strobe_o, .m_rw_o, .fill_line_o(fill_line)
    );

endmodule

// ==== source/flush_counter.sv ====
`timescale 1ns/10ps

module flush_counter
(
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                walk_step_i,
    output logic [dcache_pkg::INDEX_BITS-1:0]   walk_set_o,
    output logic [dcache_pkg::WAY_BITS-1:0]     walk_way_o,
    output logic                                walk_end_o
);
    import dcache_pkg::*;

    logic last_set;
    logic last_entry;

    assign last_set   = (walk_set_o == INDEX_BITS'(N_SETS - 1));
    assign last_entry = last_set && (walk_way_o == WAY_BITS'(N_WAYS - 1));

    // Sets inner, ways outer, both wrap back to zero after the walk
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            walk_set_o <= '0;
            walk_way_o <= '0;
            walk_end_o <= 1'b0;
        end
        else
        begin
            if (walk_step_i)
            begin
                walk_set_o <= walk_set_o + 1'b1;
                if (last_set)
                    walk_way_o <= walk_way_o + 1'b1;   // Next way on set wrap
            end
            walk_end_o <= last_entry;   // Seen one cycle later, in the done state
        end
    end

endmodule

// ==== source/line_merge.sv ====
`timescale 1ns/10ps

module line_merge
(
    input  logic [dcache_pkg::OFFSET_BITS-1:0]  offset_i,
    input  logic [dcache_pkg::XLEN/8-1:0]       be_i,
    input  logic [dcache_pkg::XLEN-1:0]         wdata_i,
    input  logic                                req_rw_i,
    input  logic [dcache_pkg::LINE_W-1:0]       base_line_i,
    output logic [dcache_pkg::XLEN-1:0]         rdata_o,
    output logic [dcache_pkg::LINE_W-1:0]       write_line_o
);
    import dcache_pkg::*;

    logic [OFFSET_BITS-1:0] pos;        // Word slot counted from the bottom
    logic [XLEN-1:0]        byte_mask;
    logic [XLEN-1:0]        merged;
    logic                   be_legal;

    // Offset 0 is the top word of the line
    assign pos     = OFFSET_BITS'(WORDS_PER_LINE - 1) - offset_i;
    assign rdata_o = base_line_i[pos*XLEN +: XLEN];

    // Byte, aligned half and full word patterns only
    always_comb
    begin
        case (be_i)
            4'b0001, 4'b0010, 4'b0100, 4'b1000:
                be_legal = 1'b1;
            4'b0011, 4'b1100, 4'b1111:
                be_legal = 1'b1;
            default:
                be_legal = 1'b0;
        endcase
    end

    always_comb
    begin
        for (int b = 0; b < XLEN/8; b++)
            byte_mask[b*8 +: 8] = {8{be_i[b]}};
    end

    assign merged = be_legal ? ((wdata_i & byte_mask) | (rdata_o & ~byte_mask)) : rdata_o;

    // Reads pass the line through untouched
    always_comb
    begin
        write_line_o = base_line_i;
        if (req_rw_i)
            write_line_o[pos*XLEN +: XLEN] = merged;
    end

endmodule

// ==== source/mem_port.sv ====
`timescale 1ns/10ps

module mem_port
(
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                m_ready_i,
    input  logic [dcache_pkg::LINE_W-1:0]       m_data_i,
    input  logic                                st_wb_victim_i,
    input  logic                                st_fill_i,
    input  logic                                st_wb_walk_i,
    input  logic                                walk_dirty_i,
    input  dcache_pkg::dc_addr_u                req_addr_i,
    input  logic [dcache_pkg::TAG_BITS-1:0]     victim_tag_i,
    input  logic [dcache_pkg::LINE_W-1:0]       victim_line_i,
    input  logic [dcache_pkg::INDEX_BITS-1:0]   walk_set_i,
    input  logic [dcache_pkg::TAG_BITS-1:0]     walk_tag_i,
    input  logic [dcache_pkg::LINE_W-1:0]       walk_line_i,
    output dcache_pkg::dc_addr_u                m_addr_o,
    output logic [dcache_pkg::LINE_W-1:0]       m_data_o,
    output logic                                m_strobe_o,
    output logic                                m_rw_o,
    output logic [dcache_pkg::LINE_W-1:0]       fill_line_o
);
    import dcache_pkg::*;

    logic              walk_wb;     // Dirty entry under the walk
    logic              mem_req;
    dc_addr_u          line_addr;
    logic [LINE_W-1:0] wb_line;

    assign walk_wb = st_wb_walk_i && walk_dirty_i;
    assign mem_req = st_wb_victim_i || st_fill_i || walk_wb;

    // Line aligned address, fill uses the request tag and set
    always_comb
    begin
        line_addr            = req_addr_i;
        line_addr.f.offset   = '0;
        line_addr.f.byte_sel = '0;
        wb_line              = victim_line_i;
        if (walk_wb)
        begin
            line_addr.f.tag   = walk_tag_i;
            line_addr.f.index = walk_set_i;
            wb_line           = walk_line_i;
        end
        else if (st_wb_victim_i)
            line_addr.f.tag = victim_tag_i;   // Victim shares the request set
    end

    // ==========================================================
    // Memory side registers
    // ==========================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
        end
        else
        begin
            m_strobe_o <= mem_req && !m_ready_i;   // Drops the cycle after ready
            m_rw_o     <= (st_wb_victim_i || walk_wb) && !m_ready_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (mem_req)
        begin
            m_addr_o <= line_addr;
            m_data_o <= wb_line;
        end
        if (st_fill_i && m_ready_i)
            fill_line_o <= m_data_i;   // Line arrives with ready
    end

endmodule

// ==== test/dcache_cases.txt ====
# op addr be wdata expected  (R read, H read that must hit, W write, F flush with
# expected memory writes, M model memory word, B last write-back address and word)
R 00001044 0 00000000 a5a51044
H 00001058 0 00000000 a5a51058
W 00001048 3 11223344 00000000
H 00001048 0 00000000 a5a53344
W 0000104c 8 de000000 00000000
H 0000104c 0 00000000 dea5104c
W 00001050 5 ffffffff 00000000
H 00001050 0 00000000 a5a51050
W 00002084 f cafef00d 00000000
H 00002084 0 00000000 cafef00d
M 00002084 0 00000000 a5a52084
W 00000064 c beef0000 00000000
R 00000264 0 00000000 a5a50264
R 00000464 0 00000000 a5a50464
R 00000664 0 00000000 a5a50664
M 00000064 0 00000000 a5a50064
R 00000864 0 00000000 a5a50864
B 00000064 0 00000000 beef0064
M 00000064 0 00000000 beef0064
R 00000064 0 00000000 beef0064
F 00000000 0 00000000 00000002
M 00001048 0 00000000 a5a53344
M 0000104c 0 00000000 dea5104c
M 00001050 0 00000000 a5a51050
M 00002084 0 00000000 cafef00d
M 00000064 0 00000000 beef0064
F 00000000 0 00000000 00000000
H 00001048 0 00000000 a5a53344

// ==== test/dcache_props.sv ====
`timescale 1ns/10ps

module dcache_props
(
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 p_flush_i,
    input logic                 p_ready_o,
    input logic                 busy_flushing_o,
    input dcache_pkg::dc_addr_u m_addr_o,
    input logic                 m_strobe_o,
    input logic                 m_ready_i
);
    int fail_count = 0;   // Summed into the testbench error count

    // Completion is a single-cycle pulse
    a_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_o |=> !p_ready_o)
    else
    begin
        $error("p_ready_o high for a second cycle");
        fail_count++;
    end

    // Memory request held steady until ready
    a_strobe_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_o && !m_ready_i |=> m_strobe_o && $stable(m_addr_o))
    else
    begin
        $error("m_strobe_o or m_addr_o changed before m_ready_i");
        fail_count++;
    end

    // Flush flag only from a flush request
    a_busy_rise: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(busy_flushing_o) |-> $past(p_flush_i))
    else
    begin
        $error("busy_flushing_o rose without p_flush_i");
        fail_count++;
    end

endmodule

bind dcache_top dcache_props u_props (.*);

// ==== test/tb_dcache.sv ====
`timescale 1ns/10ps

module tb_dcache;
    import dcache_pkg::*;

    logic               clk_i;
    logic               rst_i;
    logic               p_strobe_i;
    logic               p_rw_i;
    logic [XLEN/8-1:0]  p_byte_enable_i;
    dc_addr_u           p_addr_i;
    logic [XLEN-1:0]    p_data_i;
    logic               p_flush_i;
    logic [XLEN-1:0]    p_data_o;
    logic               p_ready_o;
    logic               busy_flushing_o;
    dc_addr_u           m_addr_o;
    logic [LINE_W-1:0]  m_data_i;
    logic [LINE_W-1:0]  m_data_o;
    logic               m_strobe_o;
    logic               m_rw_o;
    logic               m_ready_i;

    // Memory model, untouched lines keep their start pattern
    logic [LINE_W-1:0]  mem_lines [logic [XLEN-1:0]];   // Keyed by line address
    dc_addr_u           mem_addr;
    dc_addr_u           last_wb_addr;
    logic [LINE_W-1:0]  last_wb_line;
    int                 mem_writes;
    int                 wait_cycles;
    integer             seed;

    // Case table
    string              op_q [$];
    dc_addr_u           addr_q [$];
    logic [XLEN/8-1:0]  be_q [$];
    logic [XLEN-1:0]    wdata_q [$];
    logic [XLEN-1:0]    exp_q [$];

    int                 fd, code, latency, writes_before;
    int                 errors, checks, cycle_count, cycle_limit;
    string              line, op;
    logic [XLEN-1:0]    raw_addr, wd, ex, rdata;
    logic [XLEN/8-1:0]  be_v;

    dcache_top dut (.*);

    always #10 clk_i = ~clk_i;   // 20 ns period

    // ==========================================================
    // Compare tasks and line helpers
    // ==========================================================
    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input dc_addr_u exp, input dc_addr_u act);
        checks++;
        if (act.word !== exp.word)
        begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp.word,
                     act.word);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    function automatic dc_addr_u line_base(input dc_addr_u a);
        dc_addr_u b;
        b            = a;
        b.f.offset   = '0;
        b.f.byte_sel = '0;
        return b;
    endfunction

    // Word 0 of a line in the top bits
    function automatic logic [XLEN-1:0] line_word(input logic [LINE_W-1:0] l,
                                                  input logic [OFFSET_BITS-1:0] off);
        return l[(WORDS_PER_LINE - 1 - int'(off))*XLEN +: XLEN];
    endfunction

    function automatic logic [LINE_W-1:0] initial_line(input logic [XLEN-1:0] base);
        logic [LINE_W-1:0] l;
        logic [XLEN-1:0]   word_addr;
        for (int k = 0; k < WORDS_PER_LINE; k++)
        begin
            word_addr = base + XLEN'(k * 4);
            l[(WORDS_PER_LINE - 1 - k)*XLEN +: XLEN] = word_addr ^ 32'hA5A5_0000;
        end
        return l;
    endfunction

    function automatic logic [LINE_W-1:0] model_line(input logic [XLEN-1:0] base);
        return mem_lines.exists(base) ? mem_lines[base] : initial_line(base);
    endfunction

    // One processor request, returns cycles from strobe to ready
    task automatic do_access(input logic rw, input dc_addr_u addr, input logic [3:0] be,
                             input logic [XLEN-1:0] wdata, output int lat,
                             output logic [XLEN-1:0] data);
        p_strobe_i      = 1'b1;
        p_rw_i          = rw;
        p_addr_i        = addr;
        p_byte_enable_i = be;
        p_data_i        = wdata;
        @(negedge clk_i);
        p_strobe_i = 1'b0;
        lat        = 1;
        while (!p_ready_o)
        begin
            @(negedge clk_i);
            lat++;
        end
        data = p_data_o;
        @(negedge clk_i);   // FSM back in Idle
    endtask

    task automatic do_flush;
        p_flush_i = 1'b1;
        @(negedge clk_i);
        p_flush_i = 1'b0;
        while (!p_ready_o)
        begin
            check_bit("busy_flushing_o", 1'b1, busy_flushing_o);
            @(negedge clk_i);
        end
        check_bit("busy_flushing_o", 1'b1, busy_flushing_o);   // Still high with ready
        @(negedge clk_i);
        check_bit("busy_flushing_o", 1'b0, busy_flushing_o);
    endtask

    // ==========================================================
    // Memory model, answers each strobe after 1 to 4 cycles
    // ==========================================================
    initial
    begin
        seed       = 32'h0df1db01;
        m_ready_i  = 1'b0;
        m_data_i   = '0;
        mem_writes = 0;
        last_wb_addr = '0;
        last_wb_line = '0;
        forever
        begin
            @(negedge clk_i);
            if (m_strobe_o)
            begin
                wait_cycles = 1 + ($unsigned($random(seed)) % 4);
                repeat (wait_cycles) @(negedge clk_i);
                mem_addr = line_base(m_addr_o);
                if (m_rw_o)
                begin
                    mem_lines[mem_addr.word] = m_data_o;
                    last_wb_addr = m_addr_o;
                    last_wb_line = m_data_o;
                    mem_writes++;
                end
                else
                    m_data_i = model_line(mem_addr.word);
                m_ready_i = 1'b1;
                @(negedge clk_i);
                m_ready_i = 1'b0;
            end
        end
    end

    // Cycle limit
    always @(posedge clk_i)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial
    begin
        clk_i           = 1'b0;
        rst_i           = 1'b1;
        p_strobe_i      = 1'b0;
        p_rw_i          = 1'b0;
        p_byte_enable_i = '0;
        p_addr_i        = '0;
        p_data_i        = '0;
        p_flush_i       = 1'b0;
        errors          = 0;
        checks          = 0;
        cycle_count     = 0;

        fd = $fopen("test/dcache_cases.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the case file test/dcache_cases.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0 && line[0] != "#")
                    if ($sscanf(line, "%s %h %h %h %h", op, raw_addr, be_v, wd, ex) == 5)
                    begin
                        op_q.push_back(op);
                        addr_q.push_back(raw_addr);
                        be_q.push_back(be_v);
                        wdata_q.push_back(wd);
                        exp_q.push_back(ex);
                    end
            end
            $fclose(fd);
        end
        cycle_limit = 200 * op_q.size() + 2000;

        repeat (10) @(negedge clk_i);
        rst_i = 1'b0;
        check_bit("p_ready_o", 1'b0, p_ready_o);
        check_bit("m_strobe_o", 1'b0, m_strobe_o);
        check_bit("m_rw_o", 1'b0, m_rw_o);
        check_bit("busy_flushing_o", 1'b0, busy_flushing_o);

        foreach (op_q[i])
        begin
            case (op_q[i])
                "R", "H":
                begin
                    do_access(1'b0, addr_q[i], be_q[i], wdata_q[i], latency, rdata);
                    check_word("p_data_o", exp_q[i], rdata);
                    if (op_q[i] == "H" && latency != 1)
                    begin
                        errors++;
                        $display("Read of %h missed, ready came %0d cycles after the strobe",
                                 addr_q[i].word, latency);
                    end
                end
                "W":
                    do_access(1'b1, addr_q[i], be_q[i], wdata_q[i], latency, rdata);
                "F":
                begin
                    writes_before = mem_writes;
                    do_flush();
                    check_word("flush write count", exp_q[i], mem_writes - writes_before);
                end
                "M":   // Model memory only, no DUT traffic
                    check_word("memory word",
                               exp_q[i],
                               line_word(model_line(line_base(addr_q[i]).word),
                                         addr_q[i].f.offset));
                "B":   // Most recent write-back seen on the memory port
                begin
                    check_addr("m_addr_o", line_base(addr_q[i]), last_wb_addr);
                    check_word("m_data_o", exp_q[i], line_word(last_wb_line, addr_q[i].f.offset));
                end
                default:
                begin
                    errors++;
                    $display("Unknown operation %s in case line %0d", op_q[i], i);
                end
            endcase
        end

        @(negedge clk_i);
        errors += dut.u_props.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/dcache_pkg.sv
source/dcache_fsm.sv
source/flush_counter.sv
source/cache_ways.sv
source/line_merge.sv
source/mem_port.sv
source/dcache_top.sv
test/dcache_props.sv
test/tb_dcache.sv
